// File: common/sata_fis_pkg.sv
//******************************
// fis tag enums, dword and entry structs
// h2d frame states, link speed code
//******************************

package sata_fis_pkg;

    localparam logic [1:0] phy_speed_sata2 = 2'd2; // reported once link is up

    typedef logic [31:0] dword_t; // one sata data dword

    typedef enum logic [1:0] {
        h2d_fis_data = 2'd0, // fis body dword
        h2d_fis_head = 2'd1, // first dword of a fis
        h2d_fis_last = 2'd2  // closing dword of a fis
    } h2d_type_e;

    typedef enum logic [1:0] {
        d2h_dma      = 2'd0, // fis body dword
        d2h_fis_head = 2'd1, // first dword of a fis
        d2h_r_ok     = 2'd2, // frame good, data ignored
        d2h_r_err    = 2'd3  // frame bad, data ignored
    } d2h_type_e;

    typedef enum logic [1:0] {
        idle,    // no fis being written
        collect, // head seen, waiting for enough data
        request  // frame_req up, waiting for ack
    } h2d_state_e;

    typedef struct packed {
        h2d_type_e   tag;
        logic [1:0]  mask; // word halves, normally 2'b11
        dword_t      data;
    } h2d_entry_t;

    typedef struct packed {
        d2h_type_e   tag;
        logic [1:0]  mask;
        dword_t      data;
    } d2h_entry_t;

    typedef struct packed {
        logic [1:0]  mask; // from link, normally 2'b11
        dword_t      data;
    } ll_rx_t;

endpackage

// File: common/sata_fifo_pkg.sv
//******************************
// fifo depth, fill and word types
// fill thresholds for both paths
//******************************

package sata_fifo_pkg;

    localparam int fifo_addr_w = 9;                // 512 entries
    localparam int fifo_depth  = 1 << fifo_addr_w;

    typedef logic [fifo_addr_w:0] fifo_fill_t; // 0 .. 512
    typedef logic [35:0]          fifo_word_t; // tag + mask + dword

    // h2d side
    localparam fifo_fill_t h2d_ready_limit = 10'd504; // keep room for host pipeline
    localparam fifo_fill_t xmit_start_fill = 10'd64;  // start long fis early

    // d2h side
    localparam fifo_fill_t d2h_many_fill = 10'd8;   // burst worth reading
    localparam fifo_fill_t d2h_busy_fill = 10'd448; // link needs time to hold

    // storage must fit one tagged entry
    localparam int entry_w = 36;

    typedef logic [entry_w-1:0] entry_bits_t; // raw view of any entry

endpackage

// File: design/sata_fifo.sv
//******************************
// same-clock fwft dword fifo
//******************************
`timescale 1ns/10ps

module sata_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr,     // push wdata
    input  sata_fifo_pkg::fifo_word_t wdata,
    input  logic                      rd,     // pop head, ignored when empty
    output sata_fifo_pkg::fifo_word_t rdata,  // head entry
    output logic                      nempty,
    output sata_fifo_pkg::fifo_fill_t fill
);
    import sata_fifo_pkg::*;

    fifo_word_t             mem [fifo_depth]; // no reset on storage
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic                   full;
    logic                   wr_en;
    logic                   rd_en;

    assign full   = (fill == fifo_fill_t'(fifo_depth));
    assign nempty = (fill != '0);
    assign wr_en  = wr && !full; // overflow write dropped
    assign rd_en  = rd && nempty;
    assign rdata  = mem[rd_ptr];  // fall-through head

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill; // both or none
            endcase
        end
    end

    // writer must respect its almost-full level
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) !(wr && full)
    ) else $error("fifo write while full, entry dropped");

    a_fill_range: assert property (
        @(posedge clk) disable iff (rst) fill <= fifo_fill_t'(fifo_depth)
    ) else $error("fifo fill above depth");

endmodule

// File: h2d/h2d_frame_ctrl.sv
//******************************
// h2d fifo and frame request fsm
//******************************
`timescale 1ns/10ps

module h2d_frame_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  sata_fis_pkg::h2d_entry_t h2d_entry,    // from host
    input  logic                     h2d_valid,
    output logic                     h2d_ready,    // advisory, room left
    output sata_fis_pkg::h2d_entry_t ll_tx,        // fifo head to link
    output logic                     ll_tx_valid,
    input  logic                     ll_tx_strobe, // link pops head
    output logic                     ll_tx_last,
    output logic                     frame_req,    // held until ack
    input  logic                     frame_ack
);
    import sata_fis_pkg::*;
    import sata_fifo_pkg::*;

    h2d_state_e state;
    logic       head_pend;  // next fis head arrived during request
    fifo_word_t rdata;
    fifo_fill_t fill;
    logic       head_wr;
    logic       last_wr;
    logic       fill_start; // enough of an open fis is buffered

    assign head_wr    = h2d_valid && (h2d_entry.tag == h2d_fis_head);
    assign last_wr    = h2d_valid && (h2d_entry.tag == h2d_fis_last);
    assign fill_start = (fill >= xmit_start_fill) ||
                        (h2d_valid && (fill == xmit_start_fill - 1'b1)); // this write hits 64

    sata_fifo fifo_h2d_i (
        .clk    (clk),
        .rst    (rst),
        .wr     (h2d_valid),
        .wdata  (fifo_word_t'(h2d_entry)),
        .rd     (ll_tx_strobe), // empty strobe ignored inside
        .rdata  (rdata),
        .nempty (ll_tx_valid),
        .fill   (fill)
    );

    assign ll_tx      = h2d_entry_t'(rdata);
    assign ll_tx_last = (ll_tx.tag == h2d_fis_last);
    assign h2d_ready  = (fill < h2d_ready_limit);
    assign frame_req  = (state == request);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (head_wr) state <= collect;
                collect: if (last_wr || fill_start) state <= request;
                request: if (frame_ack) state <= (head_pend || head_wr) ? collect : idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_pend <= 1'b0;
        end else begin
            head_pend <= (state == request) && !frame_ack && (head_pend || head_wr);
        end
    end

    a_ack_in_req: assert property (
        @(posedge clk) disable iff (rst) frame_ack |-> frame_req
    ) else $error("frame_ack without frame_req");

    a_host_flow: assert property (
        @(posedge clk) disable iff (rst) h2d_valid |-> h2d_ready
    ) else $error("host wrote while h2d_ready low");

endmodule

// File: d2h/d2h_fis_tagger.sv
//******************************
// d2h tagging, r_ok/r_err entries
// d2h fifo with many and busy levels
//******************************
`timescale 1ns/10ps

module d2h_fis_tagger (
    input  logic                     clk,
    input  logic                     rst,
    input  sata_fis_pkg::ll_rx_t     ll_rx,            // dword from link
    input  logic                     ll_rx_valid,
    input  logic                     incom_start,      // single-cycle pulses
    input  logic                     incom_done,
    input  logic                     incom_invalidate,
    output logic                     ll_rx_busy,       // almost full level
    output sata_fis_pkg::d2h_entry_t d2h_entry,
    output logic                     d2h_valid,
    output logic                     d2h_many,
    input  logic                     d2h_ready
);
    import sata_fis_pkg::*;
    import sata_fifo_pkg::*;

    d2h_type_e  rx_tag;   // tag for next pushed entry
    logic       end_r;    // push the closing status entry
    ll_rx_t     last_rx;  // last received dword, reused by status entry
    fifo_word_t wdata;
    fifo_word_t rdata;
    fifo_fill_t fill;

    always_ff @(posedge clk) begin
        if (rst || incom_start) begin
            rx_tag <= d2h_fis_head;
        end else if (ll_rx_valid) begin
            rx_tag <= d2h_dma; // rest of fis body
        end else if (incom_done || incom_invalidate) begin
            rx_tag <= incom_invalidate ? d2h_r_err : d2h_r_ok;
        end
    end

    // only once per frame, and only if data went in
    always_ff @(posedge clk) begin
        if (rst) begin
            end_r <= 1'b0;
        end else begin
            end_r <= (incom_done || incom_invalidate) && (rx_tag == d2h_dma);
        end
    end

    always_ff @(posedge clk) begin
        if (ll_rx_valid) begin
            last_rx <= ll_rx;
        end
    end

    assign wdata = end_r ? fifo_word_t'({rx_tag, last_rx}) : fifo_word_t'({rx_tag, ll_rx});

    sata_fifo fifo_d2h_i (
        .clk    (clk),
        .rst    (rst),
        .wr     (ll_rx_valid || end_r),
        .wdata  (wdata),
        .rd     (d2h_valid && d2h_ready),
        .rdata  (rdata),
        .nempty (d2h_valid),
        .fill   (fill)
    );

    assign d2h_entry  = d2h_entry_t'(rdata);
    assign d2h_many   = (fill >= d2h_many_fill);
    assign ll_rx_busy = (fill >= d2h_busy_fill);

    // link stays quiet between end of frame and status push
    a_end_gap: assert property (
        @(posedge clk) disable iff (rst) end_r |-> !ll_rx_valid
    ) else $error("link dword collided with status entry");

endmodule

// File: design/sata_transport_glue.sv
//******************************
// transport glue top, h2d and d2h
// paths plus status flags
//******************************
`timescale 1ns/10ps

module sata_transport_glue (
    input  logic                     clk,
    input  logic                     rst,
    // host h2d
    input  sata_fis_pkg::h2d_entry_t h2d_entry,
    input  logic                     h2d_valid,
    output logic                     h2d_ready,
    // link h2d
    output sata_fis_pkg::h2d_entry_t ll_tx,
    output logic                     ll_tx_valid,
    input  logic                     ll_tx_strobe,
    output logic                     ll_tx_last,
    output logic                     frame_req,
    input  logic                     frame_ack,
    // link d2h
    input  sata_fis_pkg::ll_rx_t     ll_rx,
    input  logic                     ll_rx_valid,
    input  logic                     incom_start,
    input  logic                     incom_done,
    input  logic                     incom_invalidate,
    output logic                     ll_rx_busy,
    // host d2h
    output sata_fis_pkg::d2h_entry_t d2h_entry,
    output logic                     d2h_valid,
    output logic                     d2h_many,
    input  logic                     d2h_ready,
    // status
    input  logic                     link_established,
    input  logic [3:0]               phy_err,          // per byte decode error
    input  logic                     frame_done_bad,   // device answered r_err
    output logic [1:0]               phy_speed,
    output logic                     serr_db,
    output logic                     serr_dh
);
    import sata_fis_pkg::*;

    h2d_frame_ctrl h2d_frame_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .h2d_entry    (h2d_entry),
        .h2d_valid    (h2d_valid),
        .h2d_ready    (h2d_ready),
        .ll_tx        (ll_tx),
        .ll_tx_valid  (ll_tx_valid),
        .ll_tx_strobe (ll_tx_strobe),
        .ll_tx_last   (ll_tx_last),
        .frame_req    (frame_req),
        .frame_ack    (frame_ack)
    );

    d2h_fis_tagger d2h_fis_tagger_i (
        .clk              (clk),
        .rst              (rst),
        .ll_rx            (ll_rx),
        .ll_rx_valid      (ll_rx_valid),
        .incom_start      (incom_start),
        .incom_done       (incom_done),
        .incom_invalidate (incom_invalidate),
        .ll_rx_busy       (ll_rx_busy),
        .d2h_entry        (d2h_entry),
        .d2h_valid        (d2h_valid),
        .d2h_many         (d2h_many),
        .d2h_ready        (d2h_ready)
    );

    assign phy_speed = link_established ? phy_speed_sata2 : 2'd0; // 0 means not ready
    assign serr_db   = link_established && (|phy_err);
    assign serr_dh   = link_established && frame_done_bad;

endmodule

// File: test/tb_checks.svh
//******************************
// typed compare tasks for h2d and d2h
// entries, single bits and speed code
//******************************
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_h2d(string name, h2d_entry_t got, h2d_entry_t exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        stop_run();
    end
endtask

task automatic check_d2h(string name, d2h_entry_t got, d2h_entry_t exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        stop_run();
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        stop_run();
    end
endtask

task automatic check_speed(string name, logic [1:0] got, logic [1:0] exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        stop_run();
    end
endtask

`endif

// File: test/tb_sata_transport_glue.sv
//******************************
// transport glue testbench
// vector reader, stimulus, scoreboards
//******************************
`timescale 1ns/10ps

module tb_sata_transport_glue;
    import sata_fis_pkg::*;
    import sata_fifo_pkg::*;

    localparam int wait_limit = 2000; // cycles per wait loop

    logic       clk;
    logic       rst;
    h2d_entry_t h2d_entry;
    logic       h2d_valid;
    logic       h2d_ready;
    h2d_entry_t ll_tx;
    logic       ll_tx_valid;
    logic       ll_tx_strobe;
    logic       ll_tx_last;
    logic       frame_req;
    logic       frame_ack;
    ll_rx_t     ll_rx;
    logic       ll_rx_valid;
    logic       incom_start;
    logic       incom_done;
    logic       incom_invalidate;
    logic       ll_rx_busy;
    d2h_entry_t d2h_entry;
    logic       d2h_valid;
    logic       d2h_many;
    logic       d2h_ready;
    logic       link_established;
    logic [3:0] phy_err;
    logic       frame_done_bad;
    logic [1:0] phy_speed;
    logic       serr_db;
    logic       serr_dh;

    h2d_entry_t h2d_exp [$]; // expected at link read port
    d2h_entry_t d2h_exp [$]; // expected at host read port
    dword_t     last_rx_data; // repeated by status entries
    dword_t     lcg_state = 32'd36866;
    int         fd;

    sata_transport_glue i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    function automatic dword_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_run(string why);
        $display("error at %0t: %s", $time, why);
        stop_run();
    endtask

    task automatic expect_fields(int got, int want);
        if (got != want) fail_run("vector line has missing or bad fields");
    endtask

    `include "tb_checks.svh"

    // one host write, then frame_req as seen after that edge
    task automatic h2d_write(int tag, dword_t d, logic exp_req);
        h2d_entry_t e;
        int         cnt;
        cnt = 0;
        while (!h2d_ready) begin
            @(negedge clk);
            cnt++;
            if (cnt >= wait_limit) fail_run("h2d_ready stayed low");
        end
        e.tag  = h2d_type_e'(tag);
        e.mask = 2'b11;
        e.data = d;
        h2d_entry = e;
        h2d_valid = 1'b1;
        h2d_exp.push_back(e);
        @(negedge clk);
        h2d_valid = 1'b0;
        check_bit("frame_req", frame_req, exp_req);
    endtask

    // fifo is empty here, so write i leaves fill at i
    task automatic long_fis(int n);
        int tag;
        for (int i = 1; i <= n; i++) begin
            tag = (i == 1) ? 1 : ((i == n) ? 2 : 0);
            h2d_write(tag, lcg_next(), i >= int'(xmit_start_fill));
        end
    endtask

    task automatic ack_frame(int hold);
        for (int i = 0; i < hold; i++) begin
            check_bit("frame_req", frame_req, 1'b1); // held while waiting
            @(negedge clk);
        end
        check_bit("frame_req", frame_req, 1'b1);
        frame_ack = 1'b1;
        @(negedge clk);
        frame_ack = 1'b0;
        check_bit("frame_req", frame_req, 1'b0); // drops the cycle after ack
    endtask

    task automatic link_read(int n);
        h2d_entry_t exp;
        int         cnt;
        for (int i = 0; i < n; i++) begin
            cnt = 0;
            while (!ll_tx_valid) begin
                @(negedge clk);
                cnt++;
                if (cnt >= wait_limit) fail_run("ll_tx_valid never rose");
            end
            if (h2d_exp.size() == 0) fail_run("link read with nothing expected");
            exp = h2d_exp.pop_front();
            check_h2d("ll_tx", ll_tx, exp);
            check_bit("ll_tx_last", ll_tx_last, exp.tag == h2d_fis_last);
            ll_tx_strobe = 1'b1; // pop at next edge
            @(negedge clk);
            ll_tx_strobe = 1'b0;
        end
    endtask

    // frame body after incom_start, first word is the fis head
    task automatic rx_frame(int n);
        d2h_entry_t e;
        for (int i = 0; i < n; i++) begin
            e.tag  = (i == 0) ? d2h_fis_head : d2h_dma;
            e.mask = 2'b11;
            e.data = lcg_next();
            ll_rx.mask   = 2'b11;
            ll_rx.data   = e.data;
            ll_rx_valid  = 1'b1;
            last_rx_data = e.data;
            d2h_exp.push_back(e);
            @(negedge clk);
            ll_rx_valid = 1'b0;
        end
    endtask

    task automatic rx_end(logic invalid, int tag);
        d2h_entry_t e;
        e.tag  = d2h_type_e'(tag);
        e.mask = 2'b11;
        e.data = last_rx_data;
        d2h_exp.push_back(e);
        incom_done       = !invalid;
        incom_invalidate = invalid;
        @(negedge clk);
        incom_done       = 1'b0;
        incom_invalidate = 1'b0;
    endtask

    task automatic host_read(int n);
        d2h_entry_t exp;
        int         got;
        int         cnt;
        got = 0;
        cnt = 0;
        while (got < n) begin
            if (d2h_valid) begin
                if (d2h_exp.size() == 0) fail_run("host read with nothing expected");
                exp = d2h_exp.pop_front();
                check_d2h("d2h_entry", d2h_entry, exp);
                d2h_ready = 1'b1; // taken at next edge
                got++;
                cnt = 0;
            end else begin
                d2h_ready = 1'b0;
                cnt++;
                if (cnt >= wait_limit) fail_run("d2h_valid never rose");
            end
            @(negedge clk);
        end
        d2h_ready = 1'b0;
    endtask

    task automatic run_op(string op);
        int     n;
        int     a;
        int     b;
        int     c;
        int     e;
        int     f;
        int     g;
        dword_t d;
        if (op == "H") begin
            n = $fscanf(fd, "%d %h %d", a, d, b);
            expect_fields(n, 3);
            h2d_write(a, d, b);
        end else if (op == "A") begin
            n = $fscanf(fd, "%d", a);
            expect_fields(n, 1);
            ack_frame(a);
        end else if (op == "T") begin
            n = $fscanf(fd, "%d", a);
            expect_fields(n, 1);
            link_read(a);
        end else if (op == "L") begin
            n = $fscanf(fd, "%d", a);
            expect_fields(n, 1);
            long_fis(a);
        end else if (op == "S") begin
            incom_start = 1'b1;
            @(negedge clk);
            incom_start = 1'b0;
        end else if (op == "R") begin
            n = $fscanf(fd, "%d", a);
            expect_fields(n, 1);
            rx_frame(a);
        end else if (op == "D" || op == "I") begin
            n = $fscanf(fd, "%d", a);
            expect_fields(n, 1);
            rx_end(op == "I", a);
        end else if (op == "M") begin
            n = $fscanf(fd, "%d %d", a, b);
            expect_fields(n, 2);
            check_bit("d2h_many", d2h_many, a);
            check_bit("ll_rx_busy", ll_rx_busy, b);
        end else if (op == "G") begin
            n = $fscanf(fd, "%d", a);
            expect_fields(n, 1);
            host_read(a);
        end else if (op == "Z") begin
            n = $fscanf(fd, "%d %h %d %d %d %d", a, b, c, e, f, g);
            expect_fields(n, 6);
            link_established = a;
            phy_err          = b;
            frame_done_bad   = c;
            @(negedge clk); // combinational, inputs held
            check_speed("phy_speed", phy_speed, e);
            check_bit("serr_db", serr_db, f);
            check_bit("serr_dh", serr_dh, g);
            phy_err        = 4'h0;
            frame_done_bad = 1'b0;
        end else begin
            fail_run({"unknown vector op ", op});
        end
    endtask

    initial begin
        string             op;
        int                n;
        logic [8*256-1:0]  skip_line;
        rst = 1'b1;
        h2d_entry = '0;
        h2d_valid = 1'b0;
        ll_tx_strobe = 1'b0;
        frame_ack = 1'b0;
        ll_rx = '0;
        ll_rx_valid = 1'b0;
        incom_start = 1'b0;
        incom_done = 1'b0;
        incom_invalidate = 1'b0;
        d2h_ready = 1'b0;
        link_established = 1'b0;
        phy_err = 4'h0;
        frame_done_bad = 1'b0;
        last_rx_data = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_bit("frame_req", frame_req, 1'b0);
        check_bit("ll_tx_valid", ll_tx_valid, 1'b0);
        check_bit("d2h_valid", d2h_valid, 1'b0);
        check_bit("d2h_many", d2h_many, 1'b0);
        check_bit("ll_rx_busy", ll_rx_busy, 1'b0);
        check_bit("h2d_ready", h2d_ready, 1'b1);
        fd = $fopen("test/glue_vectors.txt", "r");
        if (fd == 0) fail_run("cannot open test/glue_vectors.txt");
        n = $fscanf(fd, "%s", op);
        while (n == 1) begin
            if (op.substr(0, 0) == "#") begin
                n = $fgets(skip_line, fd); // column notes
            end else begin
                run_op(op);
            end
            n = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
        if (h2d_exp.size() != 0 || d2h_exp.size() != 0) begin
            fail_run("expected entries were never read back");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: files.f
+incdir+test
common/sata_fis_pkg.sv
common/sata_fifo_pkg.sv
design/sata_fifo.sv
h2d/h2d_frame_ctrl.sv
d2h/d2h_fis_tagger.sv
design/sata_transport_glue.sv
test/tb_sata_transport_glue.sv

// File: test/glue_vectors.txt
# H tag data req_after | A hold | T n | L n | S | R n | D tag | I tag
# M many busy | G n | Z established phy_err bad speed serr_db serr_dh
Z 1 0 0 2 0 0
H 1 a5000001 0
H 0 a5000002 0
H 0 a5000003 0
H 0 a5000004 0
H 2 a5000005 1
A 3
T 5
L 80
A 2
T 80
S
R 12
D 2
M 1 0
G 13
S
R 4
I 3
S
R 3
D 2
M 1 0
G 9
M 0 0
Z 1 4 0 2 1 0
Z 1 0 1 2 0 1
Z 0 f 1 0 0 0
Z 1 0 0 2 0 0
